// ==== gat_layer.f ====
logic/gat_cfg_pkg.sv
logic/gat_msg_pkg.sv
logic/msg_handoff.sv
logic/param_store.sv
logic/wh_transform.sv
logic/attn_score.sv
logic/attn_softmax.sv
logic/feat_aggregator.sv
logic/gat_layer.sv
tests/gat_layer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module gat_layer_tb \
  -f gat_layer.f -o gat_layer_sim > build.log 2>&1 \
  && ./obj_dir/gat_layer_sim > sim.log 2>&1 \
  && ! grep -q "TB FAILED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== tests/gat_layer_tb.sv ====
`timescale 1ns/100ps

module gat_layer_tb
  import gat_cfg_pkg::*, gat_msg_pkg::*;
();

  localparam int CLK_HALF    = 5;
  localparam int RAND_SEED   = 68;
  localparam int JOB_BUDGET  = 120;                       // cycles per job, generous.
  localparam int TIMEOUT_CYC = 20 * JOB_BUDGET + 500;    // slack for params and hold-off.
  localparam int W_WORDS     = F_OUT * F_IN;

  logic                  clk;
  logic                  rst_n;
  logic                  prm_we_i;
  logic [PRM_ADDR_W-1:0] prm_addr_i;
  feat_t                 prm_data_i;
  logic                  job_req_i;
  job_t                  job_i;
  logic                  job_ack_o;
  logic                  res_req_o;
  logic                  res_ack_i;
  res_t                  res_o;

  params_t     cur_prm;  // host copy of the store.
  job_t        pend_jobs [$];
  res_t        pend_exp [$];
  int unsigned cycle_cnt;
  logic        prev_res_req, prev_res_ack, prev_job_req, prev_job_ack;

  gat_layer #(.F_IN(F_IN), .F_OUT(F_OUT), .NBR_SLOTS(NBR_SLOTS)) u_dut (
    .clk(clk), .rst_n(rst_n),
    .prm_we_i(prm_we_i), .prm_addr_i(prm_addr_i), .prm_data_i(prm_data_i),
    .job_req_i(job_req_i), .job_i(job_i), .job_ack_o(job_ack_o),
    .res_req_o(res_req_o), .res_ack_i(res_ack_i), .res_o(res_o)
  );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TB FAILED");
      $fatal(1, "simulation hung");
    end
  end

  always @(posedge clk) begin
    prev_res_req <= res_req_o;
    prev_res_ack <= res_ack_i;
    prev_job_req <= job_req_i;
    prev_job_ack <= job_ack_o;
  end

  // four-phase rules on both external links.
  always @(posedge clk) begin
    if (rst_n) begin
      assert (!(prev_res_req && !res_req_o) || prev_res_ack) else begin
        $display("handshake error: res_req_o fell before res_ack_i rose");
        $display("TB FAILED");
        $fatal(1, "result handshake broken");
      end
      assert (!(!prev_job_ack && job_ack_o) || prev_job_req) else begin
        $display("handshake error: job_ack_o rose while job_req_i was low");
        $display("TB FAILED");
        $fatal(1, "job handshake broken");
      end
    end
  end

  task automatic check_int(input string test, input string what, input int want, input int got);
    assert (want == got) else begin
      $display("Fail %s %s: expected %0d, actual %0d", test, what, want, got);
      $display("TB FAILED");
      $fatal(1, "mismatch in %s", test);
    end
  endtask

  task automatic check_result(input string test, input res_t want, input res_t got);
    check_int(test, "node_id", int'(want.node_id), int'(got.node_id));
    for (int k = 0; k < F_OUT; k++) begin
      check_int(test, $sformatf("feat[%0d]", k), int'($signed(want.feat[k])),
                int'($signed(got.feat[k])));
    end
  endtask

  task automatic write_word(input int addr, input feat_t data);
    @(posedge clk);
    prm_we_i   <= 1'b1;
    prm_addr_i <= PRM_ADDR_W'(addr);
    prm_data_i <= data;
  endtask

  // w[k][f] at k*F_IN+f, then a_src, then a_dst.
  task automatic write_params(input params_t p);
    for (int k = 0; k < F_OUT; k++) begin
      for (int f = 0; f < F_IN; f++) begin
        write_word(k * F_IN + f, p.w[k][f]);
      end
    end
    for (int k = 0; k < F_OUT; k++) begin
      write_word(W_WORDS + k, p.a_src[k]);
      write_word(W_WORDS + F_OUT + k, p.a_dst[k]);
    end
    @(posedge clk);
    prm_we_i <= 1'b0;
    cur_prm = p;
  endtask

  task automatic send_job(input job_t job);
    @(posedge clk);
    job_i     <= job;
    job_req_i <= 1'b1;
    do @(posedge clk); while (job_ack_o !== 1'b1);
    job_req_i <= 1'b0;
    do @(posedge clk); while (job_ack_o !== 1'b0);
  endtask

  task automatic get_result(input int hold_off, output res_t got);
    do @(posedge clk); while (res_req_o !== 1'b1);
    repeat (hold_off) @(posedge clk);
    got = res_o;
    res_ack_i <= 1'b1;
    do @(posedge clk); while (res_req_o !== 1'b0);
    res_ack_i <= 1'b0;
  endtask

  task automatic ref_model(input job_t job, output res_t want);
    logic signed [ACC_W-1:0] wh [NBR_SLOTS][F_OUT];
    logic signed [ACC_W-1:0] e [NBR_SLOTS];
    logic signed [ACC_W-1:0] s;
    logic signed [ACC_W-1:0] e_max;
    int                      alpha [NBR_SLOTS];
    int                      gap;
    int                      sum;
    for (int j = 0; j < NBR_SLOTS; j++) begin
      for (int k = 0; k < F_OUT; k++) begin
        wh[j][k] = '0;
        for (int f = 0; f < F_IN; f++) begin
          wh[j][k] = wh[j][k] + $signed(cur_prm.w[k][f]) * $signed(job.feat[j][f]);
        end
      end
    end
    s = '0;
    for (int k = 0; k < F_OUT; k++) begin
      s = s + $signed(cur_prm.a_src[k]) * wh[0][k];
    end
    for (int j = 0; j < NBR_SLOTS; j++) begin
      e[j] = s;
      for (int k = 0; k < F_OUT; k++) begin
        e[j] = e[j] + $signed(cur_prm.a_dst[k]) * wh[j][k];
      end
      if (e[j] < 0) e[j] = e[j] >>> LEAKY_SH;  // leaky relu.
    end
    e_max = e[0];
    for (int j = 1; j < NBR_SLOTS; j++) begin
      if (job.slot_vld[j] && e[j] > e_max) e_max = e[j];
    end
    for (int j = 0; j < NBR_SLOTS; j++) begin
      alpha[j] = 0;
      if (job.slot_vld[j]) begin
        gap = (int'(e_max) - int'(e[j])) / (1 << SCORE_STEP_SH);
        if (gap > ALPHA_MAX_SH) gap = ALPHA_MAX_SH;
        alpha[j] = ALPHA_ONE >> gap;
      end
    end
    want.node_id = job.node_id;
    for (int k = 0; k < F_OUT; k++) begin
      sum = 0;
      for (int j = 0; j < NBR_SLOTS; j++) begin
        sum = sum + alpha[j] * int'(wh[j][k]);
      end
      want.feat[k] = acc_t'(sum >>> ALPHA_FRAC);
    end
  endtask

  function automatic feat_t rand_feat(input int span);
    return feat_t'(int'($urandom_range(2 * span)) - span);
  endfunction

  task automatic random_job(input node_id_t id, output job_t job);
    job.node_id = id;
    for (int j = 0; j < NBR_SLOTS; j++) begin
      for (int f = 0; f < F_IN; f++) begin
        job.feat[j][f] = rand_feat(8);
      end
    end
    job.slot_vld = {(NBR_SLOTS-1)'($urandom()), 1'b1};
  endtask

  task automatic random_params();
    params_t p;
    for (int k = 0; k < F_OUT; k++) begin
      for (int f = 0; f < F_IN; f++) begin
        p.w[k][f] = rand_feat(8);
      end
      p.a_src[k] = rand_feat(3);
      p.a_dst[k] = rand_feat(3);
    end
    write_params(p);
  endtask

  task automatic queue_job(input job_t job);
    res_t want;
    ref_model(job, want);
    pend_jobs.push_back(job);
    pend_exp.push_back(want);
  endtask

  // sender and receiver run side by side, results must keep job order.
  task automatic stream_jobs(input string test, input int first_hold);
    int n;
    n = pend_jobs.size();
    fork
      begin
        for (int i = 0; i < n; i++) begin
          send_job(pend_jobs[i]);
        end
      end
      begin
        res_t got;
        for (int i = 0; i < n; i++) begin
          get_result((i == 0) ? first_hold : 0, got);
          check_result(test, pend_exp[i], got);
        end
      end
    join
    pend_jobs.delete();
    pend_exp.delete();
  endtask

  task automatic idle_after_reset();
    repeat (20) begin
      @(posedge clk);
      check_int("idle_after_reset", "job_ack_o", 0, int'(job_ack_o));
      check_int("idle_after_reset", "res_req_o", 0, int'(res_req_o));
    end
  endtask

  task automatic lone_node();
    params_t p;
    job_t    job;
    res_t    want;
    res_t    got;
    p = '0;
    for (int k = 0; k < F_OUT; k++) begin
      p.w[k][k] = 8'sd1;
    end
    p.a_src[0] = 8'sd1;
    p.a_dst[0] = 8'sd1;
    write_params(p);
    random_job(8'h21, job);  // neighbours are junk, masked off.
    job.slot_vld   = NBR_SLOTS'(1);
    job.feat[0][0] = feat_t'(5);
    job.feat[0][1] = feat_t'(-7);
    want.node_id = 8'h21;
    want.feat[0] = acc_t'(5);
    want.feat[1] = acc_t'(-7);
    send_job(job);
    get_result(0, got);
    check_result("lone_node", want, got);
  endtask

  // scores 80, 60, 30, -3 give shifts 0, 1, 3 and 5.
  task automatic full_neighbourhood();
    params_t p;
    job_t    job;
    int      col0 [NBR_SLOTS];
    int      col1 [NBR_SLOTS];
    col0 = '{40, 20, -10, -60};
    col1 = '{10, -5, 7, 100};
    p = '0;
    for (int k = 0; k < F_OUT; k++) begin
      p.w[k][k] = 8'sd1;
    end
    p.w[1][2]  = 8'sd2;
    p.a_src[0] = 8'sd1;
    p.a_dst[0] = 8'sd1;
    write_params(p);
    job.node_id  = 8'h33;
    job.slot_vld = '1;
    for (int j = 0; j < NBR_SLOTS; j++) begin
      job.feat[j][0] = feat_t'(col0[j]);
      job.feat[j][1] = feat_t'(col1[j]);
      job.feat[j][2] = feat_t'(j + 1);
      job.feat[j][3] = feat_t'(-j);
    end
    queue_job(job);
    stream_jobs("full_neighbourhood", 0);
  endtask

  task automatic random_stream();
    job_t job;
    random_params();
    for (int i = 0; i < 10; i++) begin
      random_job(node_id_t'(8'h40 + i), job);
      queue_job(job);
    end
    stream_jobs("random_stream", 0);
  endtask

  task automatic back_pressure();
    job_t job;
    for (int i = 0; i < 4; i++) begin
      random_job(node_id_t'(8'h80 + i), job);
      queue_job(job);
    end
    stream_jobs("back_pressure", 200);
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    clk          = 1'b0;
    rst_n        = 1'b0;
    prm_we_i     = 1'b0;
    prm_addr_i   = '0;
    prm_data_i   = '0;
    job_req_i    = 1'b0;
    job_i        = '0;
    res_ack_i    = 1'b0;
    cur_prm      = '0;
    cycle_cnt    = 0;
    prev_res_req = 1'b0;
    prev_res_ack = 1'b0;
    prev_job_req = 1'b0;
    prev_job_ack = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    idle_after_reset();
    lone_node();
    full_neighbourhood();
    random_stream();
    back_pressure();
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== logic/gat_layer.sv ====
`timescale 1ns/100ps

module gat_layer import gat_cfg_pkg::*, gat_msg_pkg::*; #(
  parameter int F_IN      = gat_cfg_pkg::F_IN,
  parameter int F_OUT     = gat_cfg_pkg::F_OUT,
  parameter int NBR_SLOTS = gat_cfg_pkg::NBR_SLOTS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  prm_we_i,
  input  logic [PRM_ADDR_W-1:0] prm_addr_i,
  input  feat_t                 prm_data_i,
  input  logic                  job_req_i,
  input  job_t                  job_i,
  output logic                  job_ack_o,
  output logic                  res_req_o,
  input  logic                  res_ack_i,
  output res_t                  res_o
);

  params_t    params;
  logic       wh_req, wh_ack;
  wh_msg_t    wh_msg;
  logic       sc_req, sc_ack;
  score_msg_t sc_msg;
  logic       al_req, al_ack;
  alpha_msg_t al_msg;

  // host writes only while no job is in flight.
  param_store u_param_store (
    .clk(clk), .rst_n(rst_n),
    .prm_we_i(prm_we_i), .prm_addr_i(prm_addr_i), .prm_data_i(prm_data_i),
    .params_o(params)
  );

  wh_transform #(.F_IN(F_IN), .F_OUT(F_OUT), .NBR_SLOTS(NBR_SLOTS)) u_wh_transform (
    .clk(clk), .rst_n(rst_n), .params_i(params),
    .job_req_i(job_req_i), .job_i(job_i), .job_ack_o(job_ack_o),
    .wh_req_o(wh_req), .wh_ack_i(wh_ack), .wh_o(wh_msg)
  );

  attn_score #(.F_OUT(F_OUT), .NBR_SLOTS(NBR_SLOTS)) u_attn_score (
    .clk(clk), .rst_n(rst_n), .params_i(params),
    .wh_req_i(wh_req), .wh_i(wh_msg), .wh_ack_o(wh_ack),
    .sc_req_o(sc_req), .sc_ack_i(sc_ack), .sc_o(sc_msg)
  );

  attn_softmax #(.NBR_SLOTS(NBR_SLOTS)) u_attn_softmax (
    .clk(clk), .rst_n(rst_n),
    .sc_req_i(sc_req), .sc_i(sc_msg), .sc_ack_o(sc_ack),
    .al_req_o(al_req), .al_ack_i(al_ack), .al_o(al_msg)
  );

  feat_aggregator #(.F_OUT(F_OUT), .NBR_SLOTS(NBR_SLOTS)) u_feat_aggregator (
    .clk(clk), .rst_n(rst_n),
    .al_req_i(al_req), .al_i(al_msg), .al_ack_o(al_ack),
    .res_req_o(res_req_o), .res_ack_i(res_ack_i), .res_o(res_o)
  );

endmodule

// ==== logic/feat_aggregator.sv ====
`timescale 1ns/100ps

module feat_aggregator import gat_cfg_pkg::*, gat_msg_pkg::*; #(
  parameter int F_OUT     = gat_cfg_pkg::F_OUT,
  parameter int NBR_SLOTS = gat_cfg_pkg::NBR_SLOTS
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       al_req_i,
  input  alpha_msg_t al_i,
  output logic       al_ack_o,
  output logic       res_req_o,
  input  logic       res_ack_i,
  output res_t       res_o
);

  localparam int KW    = (F_OUT > 1) ? $clog2(F_OUT) : 1;
  localparam int JW    = (NBR_SLOTS > 1) ? $clog2(NBR_SLOTS) : 1;
  localparam int SUM_W = ACC_W + ALPHA_W + 2;

  typedef enum logic [1:0] {ST_IDLE, ST_MAC, ST_SEND} state_e;

  state_e                  state;
  logic [KW-1:0]           k_q;
  logic [JW-1:0]           j_q;
  logic                    last_k, last_j;
  logic                    accept;
  logic                    ho_busy;
  logic signed [SUM_W-1:0] sum_q;
  logic signed [SUM_W-1:0] sum_nxt;
  alpha_msg_t              al_q;
  res_t                    res_q;

  assign accept  = (state == ST_IDLE) && !ho_busy && al_req_i && !al_ack_o;
  assign last_k  = (k_q == KW'(F_OUT - 1));
  assign last_j  = (j_q == JW'(NBR_SLOTS - 1));
  assign sum_nxt = sum_q + $signed({1'b0, al_q.alpha[j_q]}) * $signed(al_q.wh[j_q][k_q]);

  // element outer, slot inner. invalid slots carry alpha 0.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      k_q      <= '0;
      j_q      <= '0;
      sum_q    <= '0;
      al_ack_o <= 1'b0;
    end else begin
      if (accept) begin
        al_ack_o <= 1'b1;
      end else if (al_ack_o && !al_req_i) begin
        al_ack_o <= 1'b0;
      end
      case (state)
        ST_IDLE: if (accept) state <= ST_MAC;
        ST_MAC: begin
          j_q   <= last_j ? '0 : j_q + 1'b1;
          sum_q <= last_j ? '0 : sum_nxt;
          if (last_j) begin
            k_q <= last_k ? '0 : k_q + 1'b1;
            if (last_k) state <= ST_SEND;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      al_q          <= al_i;
      res_q.node_id <= al_i.node_id;
    end
    if (state == ST_MAC && last_j) begin
      res_q.feat[k_q] <= ACC_W'(sum_nxt >>> ALPHA_FRAC);  // drop the alpha fraction.
    end
  end

  msg_handoff #(.payload_t(res_t)) u_handoff (
    .clk(clk), .rst_n(rst_n),
    .load_i(state == ST_SEND), .data_i(res_q), .busy_o(ho_busy),
    .req_o(res_req_o), .ack_i(res_ack_i), .data_o(res_o)
  );

endmodule

// ==== logic/attn_softmax.sv ====
`timescale 1ns/100ps

module attn_softmax import gat_cfg_pkg::*, gat_msg_pkg::*; #(
  parameter int NBR_SLOTS = gat_cfg_pkg::NBR_SLOTS
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sc_req_i,
  input  score_msg_t sc_i,
  output logic       sc_ack_o,
  output logic       al_req_o,
  input  logic       al_ack_i,
  output alpha_msg_t al_o
);

  localparam int     JW     = (NBR_SLOTS > 1) ? $clog2(NBR_SLOTS) : 1;
  localparam int     DIFF_W = ACC_W + 1;
  localparam int     SH_W   = $clog2(ALPHA_MAX_SH + 1);
  localparam alpha_t ONE    = ALPHA_W'(ALPHA_ONE);

  typedef enum logic [1:0] {ST_IDLE, ST_MAX, ST_ALPHA, ST_SEND} state_e;

  state_e               state;
  logic [JW-1:0]        j_q;
  logic                 last_j;
  logic                 accept;
  logic                 ho_busy;
  logic                 has_one;
  acc_t                 max_q;
  acc_t                 cur;
  logic [DIFF_W-1:0]    diff;
  logic [DIFF_W-1:0]    step;
  logic [SH_W-1:0]      sh;
  alpha_t               alpha_cur;
  acc_t [NBR_SLOTS-1:0] score_q;
  alpha_msg_t           al_q;

  assign accept    = (state == ST_IDLE) && !ho_busy && sc_req_i && !sc_ack_o;
  assign last_j    = (j_q == JW'(NBR_SLOTS - 1));
  assign cur       = score_q[j_q];
  assign diff      = DIFF_W'(max_q) - DIFF_W'(cur);  // one extra bit, never negative.
  assign step      = diff >> SCORE_STEP_SH;
  assign sh        = (step > DIFF_W'(ALPHA_MAX_SH)) ? SH_W'(ALPHA_MAX_SH) : step[SH_W-1:0];
  assign alpha_cur = al_q.slot_vld[j_q] ? (ONE >> sh) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      j_q      <= '0;
      sc_ack_o <= 1'b0;
    end else begin
      if (accept) begin
        sc_ack_o <= 1'b1;
      end else if (sc_ack_o && !sc_req_i) begin
        sc_ack_o <= 1'b0;
      end
      case (state)
        ST_IDLE: if (accept) state <= ST_MAX;
        ST_MAX, ST_ALPHA: begin
          j_q <= last_j ? '0 : j_q + 1'b1;
          if (last_j) state <= (state == ST_MAX) ? ST_ALPHA : ST_SEND;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      al_q.node_id  <= sc_i.node_id;
      al_q.wh       <= sc_i.wh;
      al_q.slot_vld <= sc_i.slot_vld;
      score_q       <= sc_i.score;
      max_q         <= sc_i.score[0];  // slot 0 is always valid.
    end
    if (state == ST_MAX && al_q.slot_vld[j_q] && cur > max_q) begin
      max_q <= cur;
    end
    if (state == ST_ALPHA) begin
      al_q.alpha[j_q] <= alpha_cur;
    end
  end

  always_comb begin
    has_one = 1'b0;
    for (int j = 0; j < NBR_SLOTS; j++) begin
      has_one |= al_q.slot_vld[j] && (al_q.alpha[j] == ONE);
    end
  end

  // the max search must have landed on a valid slot.
  assert property (@(posedge clk) disable iff (!rst_n) state == ST_SEND |-> has_one)
    else $error("softmax: no valid slot got alpha one");

  msg_handoff #(.payload_t(alpha_msg_t)) u_handoff (
    .clk(clk), .rst_n(rst_n),
    .load_i(state == ST_SEND), .data_i(al_q), .busy_o(ho_busy),
    .req_o(al_req_o), .ack_i(al_ack_i), .data_o(al_o)
  );

endmodule

// ==== logic/attn_score.sv ====
`timescale 1ns/100ps

module attn_score import gat_cfg_pkg::*, gat_msg_pkg::*; #(
  parameter int F_OUT     = gat_cfg_pkg::F_OUT,
  parameter int NBR_SLOTS = gat_cfg_pkg::NBR_SLOTS
) (
  input  logic       clk,
  input  logic       rst_n,
  input  params_t    params_i,
  input  logic       wh_req_i,
  input  wh_msg_t    wh_i,
  output logic       wh_ack_o,
  output logic       sc_req_o,
  input  logic       sc_ack_i,
  output score_msg_t sc_o
);

  localparam int KW = (F_OUT > 1) ? $clog2(F_OUT) : 1;

  typedef enum logic [1:0] {ST_IDLE, ST_SRC, ST_DST, ST_SEND} state_e;

  state_e        state;
  logic [KW-1:0] k_q;
  logic          last_k;
  logic          accept;
  logic          ho_busy;
  acc_t          s_q;
  acc_t          src_prod;
  acc_t          e_q   [NBR_SLOTS];
  acc_t          e_fin [NBR_SLOTS];
  score_msg_t    sc_q;

  assign accept   = (state == ST_IDLE) && !ho_busy && wh_req_i && !wh_ack_o;
  assign last_k   = (k_q == KW'(F_OUT - 1));
  assign src_prod = $signed(params_i.a_src[k_q]) * $signed(sc_q.wh[0][k_q]);

  // one dst product per slot each cycle, sums wrap at ACC_W bits.
  always_comb begin
    for (int j = 0; j < NBR_SLOTS; j++) begin
      e_fin[j] = e_q[j] + $signed(params_i.a_dst[k_q]) * $signed(sc_q.wh[j][k_q]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      k_q      <= '0;
      wh_ack_o <= 1'b0;
    end else begin
      if (accept) begin
        wh_ack_o <= 1'b1;
      end else if (wh_ack_o && !wh_req_i) begin
        wh_ack_o <= 1'b0;
      end
      case (state)
        ST_IDLE: if (accept) state <= ST_SRC;
        ST_SRC, ST_DST: begin
          k_q <= last_k ? '0 : k_q + 1'b1;
          if (last_k) state <= (state == ST_SRC) ? ST_DST : ST_SEND;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      sc_q.node_id  <= wh_i.node_id;
      sc_q.wh       <= wh_i.wh;
      sc_q.slot_vld <= wh_i.slot_vld;
      s_q           <= '0;
    end
    if (state == ST_SRC) begin
      s_q <= s_q + src_prod;
      for (int j = 0; j < NBR_SLOTS; j++) begin
        e_q[j] <= s_q + src_prod;  // last cycle leaves the full s.
      end
    end
    if (state == ST_DST) begin
      for (int j = 0; j < NBR_SLOTS; j++) begin
        e_q[j]        <= e_fin[j];
        sc_q.score[j] <= e_fin[j][ACC_W-1] ? (e_fin[j] >>> LEAKY_SH) : e_fin[j];
      end
    end
  end

  msg_handoff #(.payload_t(score_msg_t)) u_handoff (
    .clk(clk), .rst_n(rst_n),
    .load_i(state == ST_SEND), .data_i(sc_q), .busy_o(ho_busy),
    .req_o(sc_req_o), .ack_i(sc_ack_i), .data_o(sc_o)
  );

endmodule

// ==== logic/wh_transform.sv ====
`timescale 1ns/100ps

module wh_transform import gat_cfg_pkg::*, gat_msg_pkg::*; #(
  parameter int F_IN      = gat_cfg_pkg::F_IN,
  parameter int F_OUT     = gat_cfg_pkg::F_OUT,
  parameter int NBR_SLOTS = gat_cfg_pkg::NBR_SLOTS
) (
  input  logic    clk,
  input  logic    rst_n,
  input  params_t params_i,
  input  logic    job_req_i,
  input  job_t    job_i,
  output logic    job_ack_o,
  output logic    wh_req_o,
  input  logic    wh_ack_i,
  output wh_msg_t wh_o
);

  localparam int FW = (F_IN > 1) ? $clog2(F_IN) : 1;
  localparam int KW = (F_OUT > 1) ? $clog2(F_OUT) : 1;
  localparam int JW = (NBR_SLOTS > 1) ? $clog2(NBR_SLOTS) : 1;

  typedef enum logic [1:0] {ST_IDLE, ST_MAC, ST_SEND} state_e;

  state_e        state;
  logic [FW-1:0] f_q;
  logic [KW-1:0] k_q;
  logic [JW-1:0] j_q;
  logic          last_f, last_k, last_j;
  logic          accept;
  logic          ho_busy;
  acc_t          acc_q;
  acc_t          prod;
  job_t          job_q;
  wh_msg_t       wh_q;

  assign accept = (state == ST_IDLE) && !ho_busy && job_req_i && !job_ack_o;
  assign last_f = (f_q == FW'(F_IN - 1));
  assign last_k = (k_q == KW'(F_OUT - 1));
  assign last_j = (j_q == JW'(NBR_SLOTS - 1));
  assign prod   = $signed(params_i.w[k_q][f_q]) * $signed(job_q.feat[j_q][f_q]);

  // slot outer, output element middle, input element inner.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      f_q       <= '0;
      k_q       <= '0;
      j_q       <= '0;
      acc_q     <= '0;
      job_ack_o <= 1'b0;
    end else begin
      if (accept) begin
        job_ack_o <= 1'b1;
      end else if (job_ack_o && !job_req_i) begin
        job_ack_o <= 1'b0;
      end
      case (state)
        ST_IDLE: if (accept) state <= ST_MAC;
        ST_MAC: begin
          f_q   <= last_f ? '0 : f_q + 1'b1;
          acc_q <= last_f ? '0 : acc_q + prod;
          if (last_f) begin
            k_q <= last_k ? '0 : k_q + 1'b1;
            if (last_k) begin
              j_q <= last_j ? '0 : j_q + 1'b1;
              if (last_j) state <= ST_SEND;
            end
          end
        end
        ST_SEND: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      job_q         <= job_i;
      wh_q.node_id  <= job_i.node_id;
      wh_q.slot_vld <= job_i.slot_vld;
    end
    if (state == ST_MAC && last_f) begin
      wh_q.wh[j_q][k_q] <= acc_q + prod;  // invalid slots too.
    end
  end

  msg_handoff #(.payload_t(wh_msg_t)) u_handoff (
    .clk(clk), .rst_n(rst_n),
    .load_i(state == ST_SEND), .data_i(wh_q), .busy_o(ho_busy),
    .req_o(wh_req_o), .ack_i(wh_ack_i), .data_o(wh_o)
  );

endmodule

// ==== logic/param_store.sv ====
`timescale 1ns/100ps

module param_store import gat_cfg_pkg::*, gat_msg_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  prm_we_i,
  input  logic [PRM_ADDR_W-1:0] prm_addr_i,
  input  feat_t                 prm_data_i,
  output params_t               params_o
);

  localparam int W_WORDS  = F_OUT * F_IN;
  localparam int ADDR_END = W_WORDS + 2 * F_OUT;  // one past a_dst.

  // weights row by row, then a_src, then a_dst.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      params_o <= '0;
    end else if (prm_we_i) begin
      for (int k = 0; k < F_OUT; k++) begin
        for (int f = 0; f < F_IN; f++) begin
          if (prm_addr_i == PRM_ADDR_W'(k * F_IN + f)) begin
            params_o.w[k][f] <= prm_data_i;
          end
        end
        if (prm_addr_i == PRM_ADDR_W'(W_WORDS + k)) begin
          params_o.a_src[k] <= prm_data_i;
        end
        if (prm_addr_i == PRM_ADDR_W'(W_WORDS + F_OUT + k)) begin
          params_o.a_dst[k] <= prm_data_i;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    prm_we_i |-> prm_addr_i < PRM_ADDR_W'(ADDR_END))
    else $error("param_store: write to unmapped address %0d", prm_addr_i);

endmodule

// ==== logic/msg_handoff.sv ====
`timescale 1ns/100ps

module msg_handoff #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load_i,
  input  payload_t data_i,
  output logic     busy_o,
  output logic     req_o,
  input  logic     ack_i,
  output payload_t data_o
);

  typedef enum logic [1:0] {HS_IDLE, HS_REQ, HS_DROP} hs_state_e;

  hs_state_e state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= HS_IDLE;
    end else begin
      case (state)
        HS_IDLE: if (load_i) state <= HS_REQ;
        HS_REQ:  if (ack_i) state <= HS_DROP;   // receiver has the payload.
        HS_DROP: if (!ack_i) state <= HS_IDLE;
        default: state <= HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      data_o <= data_i;
    end
  end

  assign req_o  = (state == HS_REQ);
  assign busy_o = (state != HS_IDLE);  // held until ack falls.

  assert property (@(posedge clk) disable iff (!rst_n) req_o |=> $stable(data_o))
    else $error("handoff: payload changed while req was high");
  assert property (@(posedge clk) disable iff (!rst_n) $rose(ack_i) |-> req_o)
    else $error("handoff: ack rose without a pending req");
  assert property (@(posedge clk) disable iff (!rst_n) busy_o |-> !load_i)
    else $error("handoff: load while a message is in flight");

endmodule

// ==== logic/gat_msg_pkg.sv ====
package gat_msg_pkg;

  import gat_cfg_pkg::*;

  typedef feat_t [F_IN-1:0]  feat_vec_t;
  typedef acc_t  [F_OUT-1:0] wh_vec_t;

  typedef struct packed {
    node_id_t                  node_id;
    feat_vec_t [NBR_SLOTS-1:0] feat;
    logic [NBR_SLOTS-1:0]      slot_vld;  // bit 0 always set.
  } job_t;

  typedef struct packed {
    node_id_t                node_id;
    wh_vec_t [NBR_SLOTS-1:0] wh;
    logic [NBR_SLOTS-1:0]    slot_vld;
  } wh_msg_t;

  typedef struct packed {
    node_id_t                node_id;
    wh_vec_t [NBR_SLOTS-1:0] wh;
    logic [NBR_SLOTS-1:0]    slot_vld;
    acc_t [NBR_SLOTS-1:0]    score;
  } score_msg_t;

  typedef struct packed {
    node_id_t                node_id;
    wh_vec_t [NBR_SLOTS-1:0] wh;
    logic [NBR_SLOTS-1:0]    slot_vld;
    alpha_t [NBR_SLOTS-1:0]  alpha;
  } alpha_msg_t;

  typedef struct packed {
    node_id_t node_id;
    wh_vec_t  feat;
  } res_t;

  typedef struct packed {
    feat_vec_t [F_OUT-1:0] w;  // w[k][f].
    feat_t [F_OUT-1:0]     a_src;
    feat_t [F_OUT-1:0]     a_dst;
  } params_t;

endpackage

// ==== logic/gat_cfg_pkg.sv ====
package gat_cfg_pkg;

  localparam int FEAT_W     = 8;   // signed features and weights.
  localparam int F_IN       = 4;
  localparam int F_OUT      = 2;
  localparam int NBR_SLOTS  = 4;   // slot 0 is the node itself.
  localparam int NODE_W     = 8;
  localparam int PRM_ADDR_W = 5;

  localparam int ACC_W      = 20;  // wh elements and scores.
  localparam int ALPHA_W    = 8;
  localparam int ALPHA_ONE  = 128;
  localparam int ALPHA_FRAC = 7;   // alpha is a q1.7 fraction.

  // softmax step and leaky relu slope.
  localparam int SCORE_STEP_SH = 4;
  localparam int LEAKY_SH      = 3;
  localparam int ALPHA_MAX_SH  = 7;

  typedef logic signed [FEAT_W-1:0] feat_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic [ALPHA_W-1:0]       alpha_t;
  typedef logic [NODE_W-1:0]        node_id_t;

endpackage
